// File: logic/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Input queue depth and the producer's credits after reset
`define LSU_IN_CREDITS 4

// Responses the consumer may have outstanding after reset
`define LSU_OUT_CREDITS 2

// Data memory depth in 32-bit words
`define LSU_DMEM_WORDS 64

// RV32I major opcodes
`define LSU_OP_LOAD 7'b0000011
`define LSU_OP_STORE 7'b0100011

`endif

// File: logic/lsu_pkg.sv
package lsu_pkg;

    typedef logic [31:0] word_t;

    // I-type layout used by loads
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fields_t;

    // S-type layout used by stores
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fields_t;

    // One instruction word with two readings
    typedef union packed {
        i_fields_t i;
        s_fields_t s;
    } instr_u;

    // Encodings match funct3
    // Stores reuse LB, LH and LW for SB, SH and SW
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } access_t;

    typedef enum logic [1:0] {
        FAULT_NONE       = 2'b00,
        FAULT_MISALIGNED = 2'b01,
        FAULT_ILLEGAL    = 2'b10
    } fault_t;

endpackage

// File: logic/mem_decode.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module mem_decode (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                in_valid,
    input  lsu_pkg::word_t      in_instr,
    input  lsu_pkg::word_t      in_rs1_data,
    input  lsu_pkg::word_t      in_rs2_data,
    input  logic                advance,
    output logic                in_credit,
    output logic                dec_valid,
    output lsu_pkg::access_t    dec_access,
    output logic                dec_store,
    output logic                dec_illegal,
    output logic [4:0]          dec_rd,
    output lsu_pkg::word_t      dec_imm,
    output lsu_pkg::word_t      dec_rs1_data,
    output lsu_pkg::word_t      dec_rs2_data
);

    localparam int PW = $clog2(`LSU_IN_CREDITS);
    localparam int CW = $clog2(`LSU_IN_CREDITS + 1);

    // Queue storage
    lsu_pkg::word_t q_instr [`LSU_IN_CREDITS];
    lsu_pkg::word_t q_rs1 [`LSU_IN_CREDITS];
    lsu_pkg::word_t q_rs2 [`LSU_IN_CREDITS];

    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic pop;

    lsu_pkg::instr_u head;
    lsu_pkg::access_t head_access;
    logic is_load;
    logic is_store;
    logic load_ok;
    logic store_ok;
    lsu_pkg::word_t imm;

    assign pop = advance && (count != '0);

    always_ff @(posedge CLK) begin
        if (in_valid) begin
            q_instr[wr_ptr] <= in_instr;
            q_rs1[wr_ptr] <= in_rs1_data;
            q_rs2[wr_ptr] <= in_rs2_data;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid)
                wr_ptr <= (wr_ptr == PW'(`LSU_IN_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PW'(`LSU_IN_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // One credit back per popped entry
            in_credit <= pop;
        end
    end

    // Head word seen as both formats
    assign head = q_instr[rd_ptr];
    assign head_access = lsu_pkg::access_t'(head.i.funct3);

    always_comb begin
        is_load = (head.i.opcode == `LSU_OP_LOAD);
        is_store = (head.s.opcode == `LSU_OP_STORE);
        case (head_access)
            lsu_pkg::LB, lsu_pkg::LH, lsu_pkg::LW: begin
                load_ok = 1'b1;
                store_ok = 1'b1;
            end
            lsu_pkg::LBU, lsu_pkg::LHU: begin
                load_ok = 1'b1;
                store_ok = 1'b0;
            end
            default: begin
                load_ok = 1'b0;
                store_ok = 1'b0;
            end
        endcase
        // Split immediate for stores
        if (is_store)
            imm = {{20{head.s.imm_hi[6]}}, head.s.imm_hi, head.s.imm_lo};
        else
            imm = {{20{head.i.imm12[11]}}, head.i.imm12};
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            dec_valid <= 1'b0;
        else if (advance)
            dec_valid <= pop;
    end

    always_ff @(posedge CLK) begin
        if (pop) begin
            dec_access <= head_access;
            dec_store <= is_store;
            dec_illegal <= !((is_load && load_ok) || (is_store && store_ok));
            dec_rd <= is_load ? head.i.rd : 5'd0;
            dec_imm <= imm;
            dec_rs1_data <= q_rs1[rd_ptr];
            dec_rs2_data <= q_rs2[rd_ptr];
        end
    end

    // Producer must hold a credit for every word it sends
    a_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        in_valid |-> (count < CW'(`LSU_IN_CREDITS)));

endmodule

// File: logic/addr_execute.sv
`timescale 1ns/100ps

module addr_execute (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                advance,
    input  logic                dec_valid,
    input  lsu_pkg::access_t    dec_access,
    input  logic                dec_store,
    input  logic                dec_illegal,
    input  logic [4:0]          dec_rd,
    input  lsu_pkg::word_t      dec_imm,
    input  lsu_pkg::word_t      dec_rs1_data,
    input  lsu_pkg::word_t      dec_rs2_data,
    output logic                ex_valid,
    output logic                ex_store,
    output lsu_pkg::access_t    ex_access,
    output logic [4:0]          ex_rd,
    output lsu_pkg::fault_t     ex_fault,
    output lsu_pkg::word_t      ex_addr,
    output logic [3:0]          ex_byte_en,
    output lsu_pkg::word_t      ex_wdata
);

    lsu_pkg::word_t eff_addr;
    logic [1:0] offset;
    logic [3:0] lane_en;
    logic misaligned;
    lsu_pkg::fault_t fault;
    lsu_pkg::word_t wdata;

    assign eff_addr = dec_rs1_data + dec_imm;
    assign offset = eff_addr[1:0];

    always_comb begin
        lane_en = 4'b0000;
        misaligned = 1'b0;
        wdata = '0;
        case (dec_access)
            lsu_pkg::LB, lsu_pkg::LBU: begin
                lane_en = 4'b0001 << offset;
                wdata = {4{dec_rs2_data[7:0]}};
            end
            lsu_pkg::LH, lsu_pkg::LHU: begin
                lane_en = offset[1] ? 4'b1100 : 4'b0011;
                misaligned = offset[0];
                wdata = {2{dec_rs2_data[15:0]}};
            end
            lsu_pkg::LW: begin
                lane_en = 4'b1111;
                misaligned = (offset != 2'b00);
                wdata = dec_rs2_data;
            end
            default: lane_en = 4'b0000;
        endcase

        // Illegal wins over misaligned
        if (dec_illegal)
            fault = lsu_pkg::FAULT_ILLEGAL;
        else if (misaligned)
            fault = lsu_pkg::FAULT_MISALIGNED;
        else
            fault = lsu_pkg::FAULT_NONE;
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            ex_valid <= 1'b0;
        else if (advance)
            ex_valid <= dec_valid;
    end

    always_ff @(posedge CLK) begin
        if (advance) begin
            ex_store <= dec_store;
            ex_access <= dec_access;
            ex_rd <= dec_rd;
            ex_fault <= fault;
            ex_addr <= eff_addr;
            // No memory effect on a fault
            ex_byte_en <= (fault == lsu_pkg::FAULT_NONE) ? lane_en : 4'b0000;
            ex_wdata <= wdata;
        end
    end

    // A clean entry always touches at least one byte
    a_byte_en_set: assert property (@(posedge CLK) disable iff (!nRST)
        (ex_valid && ex_fault == lsu_pkg::FAULT_NONE) |-> (ex_byte_en != 4'b0000));

endmodule

// File: logic/data_ram.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module data_ram (
    input  logic            CLK,
    input  logic            en,
    input  logic            we,
    input  logic [5:0]      word_addr,
    input  logic [3:0]      byte_en,
    input  lsu_pkg::word_t  wdata,
    output lsu_pkg::word_t  rdata
);

    lsu_pkg::word_t mem [`LSU_DMEM_WORDS];

    // Write the enabled lanes, or register the addressed word
    always_ff @(posedge CLK) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (byte_en[b])
                        mem[word_addr][b*8 +: 8] <= wdata[b*8 +: 8];
                end
            end else begin
                rdata <= mem[word_addr];
            end
        end
    end

endmodule

// File: logic/mem_result.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module mem_result (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                ex_valid,
    input  logic                ex_store,
    input  lsu_pkg::access_t    ex_access,
    input  logic [4:0]          ex_rd,
    input  lsu_pkg::fault_t     ex_fault,
    input  lsu_pkg::word_t      ex_addr,
    input  logic [3:0]          ex_byte_en,
    input  lsu_pkg::word_t      ex_wdata,
    output logic                ram_en,
    output logic                ram_we,
    output logic [3:0]          ram_byte_en,
    output lsu_pkg::word_t      ram_wdata,
    input  lsu_pkg::word_t      rdata,
    input  logic                result_credit,
    output logic                advance,
    output logic                result_valid,
    output logic [4:0]          result_rd,
    output lsu_pkg::word_t      result_data,
    output lsu_pkg::fault_t     result_fault
);

    localparam int CW = $clog2(`LSU_OUT_CREDITS + 1);

    logic resp_valid;
    logic resp_store;
    lsu_pkg::access_t resp_access;
    logic [1:0] resp_offset;
    logic [4:0] resp_rd;
    lsu_pkg::fault_t resp_fault;
    logic [CW-1:0] credits;
    logic send;
    logic [7:0] lane_byte;
    logic [15:0] lane_half;
    lsu_pkg::word_t load_data;

    assign send = resp_valid && (credits != '0);
    assign advance = !resp_valid || send;

    // RAM access only for clean entries
    assign ram_en = advance && ex_valid && (ex_fault == lsu_pkg::FAULT_NONE);
    assign ram_we = ex_store;
    assign ram_byte_en = ex_byte_en;
    assign ram_wdata = ex_wdata;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            resp_valid <= 1'b0;
            credits <= CW'(`LSU_OUT_CREDITS);
        end else begin
            if (advance)
                resp_valid <= ex_valid;
            case ({send, result_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    // Entry details kept next to the registered read
    always_ff @(posedge CLK) begin
        if (advance) begin
            resp_store <= ex_store;
            resp_access <= ex_access;
            resp_offset <= ex_addr[1:0];
            resp_rd <= ex_rd;
            resp_fault <= ex_fault;
        end
    end

    // Little-endian lane pick
    always_comb begin
        lane_byte = rdata[resp_offset*8 +: 8];
        lane_half = resp_offset[1] ? rdata[31:16] : rdata[15:0];
        case (resp_access)
            lsu_pkg::LB:  load_data = {{24{lane_byte[7]}}, lane_byte};
            lsu_pkg::LBU: load_data = {24'd0, lane_byte};
            lsu_pkg::LH:  load_data = {{16{lane_half[15]}}, lane_half};
            lsu_pkg::LHU: load_data = {16'd0, lane_half};
            lsu_pkg::LW:  load_data = rdata;
            default:      load_data = '0;
        endcase
    end

    assign result_valid = send;
    assign result_rd = resp_rd;
    assign result_fault = resp_fault;
    // Stores and faults return zero
    assign result_data = (resp_store || resp_fault != lsu_pkg::FAULT_NONE) ? '0 : load_data;

    // Consumer never returns more credits than it was given
    a_credit_bound: assert property (@(posedge CLK) disable iff (!nRST)
        credits <= CW'(`LSU_OUT_CREDITS));

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_top (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                in_valid,
    input  lsu_pkg::word_t      in_instr,
    input  lsu_pkg::word_t      in_rs1_data,
    input  lsu_pkg::word_t      in_rs2_data,
    output logic                in_credit,
    input  logic                result_credit,
    output logic                result_valid,
    output logic [4:0]          result_rd,
    output lsu_pkg::word_t      result_data,
    output lsu_pkg::fault_t     result_fault
);

    localparam int AW = $clog2(`LSU_DMEM_WORDS);

    logic advance;

    // Decode stage outputs
    logic dec_valid;
    lsu_pkg::access_t dec_access;
    logic dec_store;
    logic dec_illegal;
    logic [4:0] dec_rd;
    lsu_pkg::word_t dec_imm;
    lsu_pkg::word_t dec_rs1_data;
    lsu_pkg::word_t dec_rs2_data;

    // Execute stage outputs
    logic ex_valid;
    logic ex_store;
    lsu_pkg::access_t ex_access;
    logic [4:0] ex_rd;
    lsu_pkg::fault_t ex_fault;
    lsu_pkg::word_t ex_addr;
    logic [3:0] ex_byte_en;
    lsu_pkg::word_t ex_wdata;

    logic ram_en;
    logic ram_we;
    logic [3:0] ram_byte_en;
    lsu_pkg::word_t ram_wdata;
    lsu_pkg::word_t ram_rdata;
    logic [AW-1:0] ram_word_addr;

    // Byte address down to a word index
    assign ram_word_addr = ex_addr[AW+1:2];

    mem_decode u_decode (
        .CLK(CLK), .nRST(nRST),
        .in_valid(in_valid), .in_instr(in_instr),
        .in_rs1_data(in_rs1_data), .in_rs2_data(in_rs2_data),
        .advance(advance), .in_credit(in_credit),
        .dec_valid(dec_valid), .dec_access(dec_access),
        .dec_store(dec_store), .dec_illegal(dec_illegal),
        .dec_rd(dec_rd), .dec_imm(dec_imm),
        .dec_rs1_data(dec_rs1_data), .dec_rs2_data(dec_rs2_data)
    );

    addr_execute u_execute (
        .CLK(CLK), .nRST(nRST), .advance(advance),
        .dec_valid(dec_valid), .dec_access(dec_access),
        .dec_store(dec_store), .dec_illegal(dec_illegal),
        .dec_rd(dec_rd), .dec_imm(dec_imm),
        .dec_rs1_data(dec_rs1_data), .dec_rs2_data(dec_rs2_data),
        .ex_valid(ex_valid), .ex_store(ex_store), .ex_access(ex_access),
        .ex_rd(ex_rd), .ex_fault(ex_fault), .ex_addr(ex_addr),
        .ex_byte_en(ex_byte_en), .ex_wdata(ex_wdata)
    );

    mem_result u_result (
        .CLK(CLK), .nRST(nRST),
        .ex_valid(ex_valid), .ex_store(ex_store), .ex_access(ex_access),
        .ex_rd(ex_rd), .ex_fault(ex_fault), .ex_addr(ex_addr),
        .ex_byte_en(ex_byte_en), .ex_wdata(ex_wdata),
        .ram_en(ram_en), .ram_we(ram_we),
        .ram_byte_en(ram_byte_en), .ram_wdata(ram_wdata),
        .rdata(ram_rdata), .result_credit(result_credit),
        .advance(advance), .result_valid(result_valid),
        .result_rd(result_rd), .result_data(result_data),
        .result_fault(result_fault)
    );

    data_ram u_ram (
        .CLK(CLK), .en(ram_en), .we(ram_we),
        .word_addr(ram_word_addr), .byte_en(ram_byte_en),
        .wdata(ram_wdata), .rdata(ram_rdata)
    );

endmodule

// File: tb/lsu_tb.sv
`timescale 1ns/100ps
`include "lsu_consts.svh"

module lsu_tb;

    logic CLK;
    logic nRST;
    logic in_valid;
    lsu_pkg::word_t in_instr;
    lsu_pkg::word_t in_rs1_data;
    lsu_pkg::word_t in_rs2_data;
    logic in_credit;
    logic result_credit;
    logic result_valid;
    logic [4:0] result_rd;
    lsu_pkg::word_t result_data;
    lsu_pkg::fault_t result_fault;

    // Vector columns
    logic [31:0] vec_instr [$];
    logic [31:0] vec_rs1 [$];
    logic [31:0] vec_rs2 [$];
    logic [4:0] vec_rd [$];
    logic [31:0] vec_data [$];
    logic [1:0] vec_fault [$];

    int n_vec = 0;
    int send_idx = 0;
    int resp_count = 0;
    int prod_credits = `LSU_IN_CREDITS;
    int out_credits = `LSU_OUT_CREDITS;
    int credit_pulses = 0;
    int mismatches = 0;
    int other_errors = 0;
    logic vectors_loaded = 1'b0;
    logic [31:0] rnd = 32'h7dda2aa1;

    lsu_top u_dut (
        .CLK(CLK), .nRST(nRST),
        .in_valid(in_valid), .in_instr(in_instr),
        .in_rs1_data(in_rs1_data), .in_rs2_data(in_rs2_data),
        .in_credit(in_credit), .result_credit(result_credit),
        .result_valid(result_valid), .result_rd(result_rd),
        .result_data(result_data), .result_fault(result_fault)
    );

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic read_vectors();
        int fd;
        int got;
        string line;
        logic [31:0] f_instr;
        logic [31:0] f_rs1;
        logic [31:0] f_rs2;
        logic [4:0] f_rd;
        logic [31:0] f_data;
        logic [1:0] f_fault;
        fd = $fopen("tb/lsu_vectors.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the vector file tb/lsu_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                // Skip blank and comment lines
                if (line.len() >= 2 && line.substr(0, 1) != "//") begin
                    got = $sscanf(line, "%h %h %h %h %h %h",
                                  f_instr, f_rs1, f_rs2, f_rd, f_data, f_fault);
                    if (got == 6) begin
                        vec_instr.push_back(f_instr);
                        vec_rs1.push_back(f_rs1);
                        vec_rs2.push_back(f_rs2);
                        vec_rd.push_back(f_rd);
                        vec_data.push_back(f_data);
                        vec_fault.push_back(f_fault);
                    end
                end
            end
            $fclose(fd);
        end
        n_vec = vec_instr.size();
    endtask

    task automatic check_response();
        assert (out_credits > 0) else begin
            other_errors++;
            $display("Response at %0t was sent without an output credit", $time);
        end
        assert (resp_count < n_vec) else begin
            other_errors++;
            $display("Extra response at %0t after the last vector", $time);
        end
        if (resp_count < n_vec) begin
            assert (result_rd == vec_rd[resp_count] && result_data == vec_data[resp_count]
                    && result_fault == vec_fault[resp_count]) else begin
                mismatches++;
                $display("Mismatch at %0t: vector %0d got rd %0d data %h fault %0d, %s %0d %h %0d",
                         $time, resp_count, result_rd, result_data, result_fault,
                         "expected", vec_rd[resp_count], vec_data[resp_count],
                         vec_fault[resp_count]);
            end
            resp_count++;
        end
    endtask

    // Producer, consumer and response check share one clocked process
    always @(posedge CLK) begin
        if (nRST) begin
            if (in_credit) begin
                prod_credits++;
                credit_pulses++;
            end
            assert (prod_credits <= `LSU_IN_CREDITS) else begin
                other_errors++;
                $display("More input credits returned than issued at %0t", $time);
            end
            if (result_valid)
                check_response();
            out_credits = out_credits + (result_credit ? 1 : 0) - (result_valid ? 1 : 0);

            // Random grants starve the output now and then
            rnd = xorshift32(rnd);
            result_credit <= (out_credits < `LSU_OUT_CREDITS) && (rnd[1:0] == 2'b00);

            if (send_idx < n_vec && prod_credits > 0) begin
                in_valid <= 1'b1;
                in_instr <= vec_instr[send_idx];
                in_rs1_data <= vec_rs1[send_idx];
                in_rs2_data <= vec_rs2[send_idx];
                send_idx++;
                prod_credits--;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    initial begin
        nRST = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        in_rs1_data = '0;
        in_rs2_data = '0;
        result_credit = 1'b0;
        read_vectors();
        assert (n_vec > 0) else begin
            other_errors++;
            $display("No vectors were read");
        end
        vectors_loaded = 1'b1;
        repeat (3) @(posedge CLK);
        nRST <= 1'b1;
        wait (resp_count == n_vec);
        // Extra cycles catch duplicate responses
        repeat (10) @(posedge CLK);
        assert (credit_pulses == n_vec) else begin
            other_errors++;
            $display("Input credit pulses %0d do not match %0d instructions sent",
                     credit_pulses, n_vec);
        end
        $display("Mismatches: %0d, other failures: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        repeat (n_vec * 40 + 10) @(posedge CLK);
        $display("Timeout: only %0d of %0d responses arrived in time", resp_count, n_vec);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/lsu_pkg.sv
logic/mem_decode.sv
logic/addr_execute.sv
logic/data_ram.sv
logic/mem_result.sv
logic/lsu_top.sv
tb/lsu_tb.sv

// File: tb/lsu_vectors.txt
// instr rs1_data rs2_data exp_rd exp_data exp_fault, all hex
// fault 0 none, 1 misaligned, 2 illegal
0020A023 00000010 89ABCDEF 00 00000000 0
00208023 00000011 0000005A 00 00000000 0
00209023 00000012 FFFF1234 00 00000000 0
0000A283 00000010 00000000 05 12345AEF 0
FE208E23 00000014 00000077 00 00000000 0
0000A303 00000010 00000000 06 12345A77 0
0220A023 00000000 80FF7F01 00 00000000 0
00008283 00000020 00000000 05 00000001 0
00008283 00000021 00000000 05 0000007F 0
00008283 00000022 00000000 05 FFFFFFFF 0
FFF08283 00000024 00000000 05 FFFFFF80 0
0000C283 00000020 00000000 05 00000001 0
0000C283 00000021 00000000 05 0000007F 0
0000C283 00000022 00000000 05 000000FF 0
0000C283 00000023 00000000 05 00000080 0
00009283 00000020 00000000 05 00007F01 0
00009283 00000022 00000000 05 FFFF80FF 0
0000D283 00000020 00000000 05 00007F01 0
0000D283 00000022 00000000 05 000080FF 0
00009283 00000021 00000000 05 00000000 1
0000A283 00000022 00000000 05 00000000 1
00209023 00000023 0000DEAD 00 00000000 1
0020A023 00000021 DEADBEEF 00 00000000 1
0000D283 00000023 00000000 05 00000000 1
0000A283 00000020 00000000 05 80FF7F01 0
00008293 00000020 00000000 00 00000000 2
0000B283 00000020 00000000 05 00000000 2
0000E283 00000020 00000000 05 00000000 2
0020C023 00000020 12345678 00 00000000 2
0000A303 00000010 00000000 06 12345A77 0
